// File: rtl/stream_mux_macros.svh
// stream mux widths and constants
`ifndef STREAM_MUX_MACROS_SVH
`define STREAM_MUX_MACROS_SVH

// ******************************
// stream and word sizes
// ******************************
`define SM_NUM_STREAMS 4            // input streams
`define SM_DATA_W      128          // payload word bits
`define SM_KEEP_W      16           // one keep bit per byte
`define SM_STAT_W      96           // status word bits

// ******************************
// fifo depths
// ******************************
`define SM_DATA_DEPTH  256          // words per data fifo
`define SM_STAT_DEPTH  64           // entries per status fifo

// ******************************
// header constants
// ******************************
`define SM_HDR_LEN_ADD 32           // added to byte length in header
`define SM_DST_MODULE  1            // destination module id

`endif

// File: rtl/stream_mux_pkg.sv
// stream mux types
`default_nettype none

`include "stream_mux_macros.svh"

package stream_mux_pkg;

    typedef logic [`SM_DATA_W-1:0]      data_word_t;    // payload or header word
    typedef logic [`SM_KEEP_W-1:0]      keep_t;         // byte mask, msb first
    typedef logic [14:0]                pkt_len_t;      // byte length
    typedef logic [`SM_NUM_STREAMS-1:0] stream_mask_t;  // one bit per stream

    // per packet status, 96 bits
    typedef struct packed {
        logic        valid;      // clear means drop the packet
        pkt_len_t    len;        // payload bytes
        logic [15:0] pkt_id;     // sequence number
        logic [63:0] timestamp;  // ingress time
    } stream_stat_t;

    // packet state machine
    typedef enum logic [1:0] {
        IDLE    = 2'd0,  // wait for a pending stream
        HEAD    = 2'd1,  // pop status, build header
        PAYLOAD = 2'd2,  // move data words out
        DISCARD = 2'd3   // drain an invalid packet
    } mux_state_e;

endpackage

`default_nettype wire

// File: rtl/cache_rd_if.sv
// cache read port
`timescale 1ns/1ps
`default_nettype none

`include "stream_mux_macros.svh"

interface cache_rd_if
    import stream_mux_pkg::*;
();

    logic [$clog2(`SM_NUM_STREAMS)-1:0] sel;  // granted stream index
    logic         pop_stat;                   // pop selected status head
    logic         pop_data;                   // pop selected data head
    stream_stat_t stat;                       // selected status head
    data_word_t   data;                       // selected data head
    stream_mask_t pending;                    // status fifos not empty

    modport cache (input sel, pop_stat, pop_data, output stat, data, pending);
    modport ctrl  (output sel, pop_stat, pop_data, input stat, data, pending);

endinterface

`default_nettype wire

// File: rtl/stream_cache.sv
// per stream input fifos
`timescale 1ns/1ps
`default_nettype none

`include "stream_mux_macros.svh"

module stream_cache
    import stream_mux_pkg::*;
(
    input  logic         user_clk,
    input  logic         user_rst_n,
    input  stream_mask_t data_wr,
    input  data_word_t   data_in [`SM_NUM_STREAMS],
    input  stream_mask_t stat_wr,
    input  stream_stat_t stat_in [`SM_NUM_STREAMS],
    output stream_mask_t rcv_ready,
    cache_rd_if.cache    rd
);

    localparam int NS  = `SM_NUM_STREAMS;
    localparam int DAW = $clog2(`SM_DATA_DEPTH);  // data pointer bits
    localparam int SAW = $clog2(`SM_STAT_DEPTH);  // status pointer bits

    typedef logic [DAW:0] dcnt_t;  // 0 .. depth
    typedef logic [SAW:0] scnt_t;

    dcnt_t        d_cnt  [NS];  // data occupancy
    scnt_t        s_cnt  [NS];  // status occupancy
    data_word_t   d_head [NS];  // fall-through heads
    stream_stat_t s_head [NS];

    // ******************************
    // one data + one status fifo per stream
    // ******************************
    for (genvar i = 0; i < NS; i++) begin : g_stream
        data_word_t     dmem [`SM_DATA_DEPTH];
        stream_stat_t   smem [`SM_STAT_DEPTH];
        logic [DAW-1:0] d_wptr;
        logic [DAW-1:0] d_rptr;
        logic [SAW-1:0] s_wptr;
        logic [SAW-1:0] s_rptr;
        logic           d_pop;
        logic           s_pop;

        assign d_pop = rd.pop_data && (rd.sel == i);  // only the selected stream
        assign s_pop = rd.pop_stat && (rd.sel == i);

        always_ff @(posedge user_clk) begin
            if (data_wr[i]) begin
                dmem[d_wptr] <= data_in[i];
            end
            if (stat_wr[i]) begin
                smem[s_wptr] <= stat_in[i];
            end
        end

        always_ff @(posedge user_clk or negedge user_rst_n) begin
            if (!user_rst_n) begin
                d_wptr   <= '0;
                d_rptr   <= '0;
                d_cnt[i] <= '0;
                s_wptr   <= '0;
                s_rptr   <= '0;
                s_cnt[i] <= '0;
            end else begin
                if (data_wr[i]) d_wptr <= d_wptr + 1'b1;
                if (d_pop)      d_rptr <= d_rptr + 1'b1;
                if (stat_wr[i]) s_wptr <= s_wptr + 1'b1;
                if (s_pop)      s_rptr <= s_rptr + 1'b1;
                d_cnt[i] <= d_cnt[i] + dcnt_t'(data_wr[i]) - dcnt_t'(d_pop);
                s_cnt[i] <= s_cnt[i] + scnt_t'(stat_wr[i]) - scnt_t'(s_pop);
            end
        end

        assign d_head[i] = dmem[d_rptr];  // head visible one edge after write
        assign s_head[i] = smem[s_rptr];

        // pops come from mux_fsm, writes from the stream sources
        a_no_pop_empty: assert property (@(posedge user_clk) disable iff (!user_rst_n)
            !(d_pop && d_cnt[i] == '0) && !(s_pop && s_cnt[i] == '0));
        a_no_write_full: assert property (@(posedge user_clk) disable iff (!user_rst_n)
            !(data_wr[i] && d_cnt[i] == dcnt_t'(`SM_DATA_DEPTH))
            && !(stat_wr[i] && s_cnt[i] == scnt_t'(`SM_STAT_DEPTH)));
    end

    // ******************************
    // selected read port and flags
    // ******************************
    always_comb begin
        for (int i = 0; i < NS; i++) begin
            rd.pending[i] = (s_cnt[i] != '0);          // packet waiting
            rcv_ready[i]  = ~|d_cnt[i][DAW:DAW-1];     // below half full
        end
    end

    assign rd.data = d_head[rd.sel];
    assign rd.stat = s_head[rd.sel];

endmodule

`default_nettype wire

// File: rtl/rr_arbiter.sv
// round robin arbiter
`timescale 1ns/1ps
`default_nettype none

`include "stream_mux_macros.svh"

module rr_arbiter
    import stream_mux_pkg::*;
(
    input  logic         user_clk,
    input  logic         user_rst_n,
    input  stream_mask_t req,
    input  logic         take,
    output stream_mask_t grant
);

    localparam int NS = `SM_NUM_STREAMS;
    localparam int IW = $clog2(NS);

    logic [IW-1:0] ptr;        // highest priority stream
    logic [IW-1:0] grant_idx;  // index of grant bit

    // first request at or after ptr, wrapping
    always_comb begin : c_pick
        logic found;
        int   idx;
        grant     = '0;
        grant_idx = ptr;
        found     = 1'b0;
        for (int k = 0; k < NS; k++) begin
            idx = (int'(ptr) + k) % NS;
            if (!found && req[idx]) begin
                grant[idx] = 1'b1;
                grant_idx  = IW'(idx);
                found      = 1'b1;
            end
        end
    end

    always_ff @(posedge user_clk or negedge user_rst_n) begin
        if (!user_rst_n) begin
            ptr <= '0;                                     // stream 0 first
        end else if (take) begin
            ptr <= IW'((int'(grant_idx) + 1) % NS);        // one past winner
        end
    end

    a_grant_onehot: assert property (@(posedge user_clk) disable iff (!user_rst_n)
        $onehot0(grant) && ((req == '0) == (grant == '0)));

endmodule

`default_nettype wire

// File: rtl/word_counter.sv
// payload word counter
`timescale 1ns/1ps
`default_nettype none

`include "stream_mux_macros.svh"

module word_counter
    import stream_mux_pkg::*;
(
    input  logic     user_clk,
    input  logic     user_rst_n,
    input  logic     load,
    input  pkt_len_t len,
    input  logic     step,
    output logic     last,
    output keep_t    last_keep
);

    localparam int BW = $clog2(`SM_KEEP_W);        // byte offset bits
    localparam int LW = $bits(pkt_len_t);
    localparam int CW = LW - BW + 1;               // room for ceil(len/16)

    logic [CW-1:0] remain;  // words still to move
    logic [BW-1:0] tail;    // bytes in the last word, 0 means full

    always_ff @(posedge user_clk or negedge user_rst_n) begin
        if (!user_rst_n) begin
            remain <= '0;
            tail   <= '0;
        end else if (load) begin
            remain <= {1'b0, len[LW-1:BW]} + CW'(|len[BW-1:0]);  // round up
            tail   <= len[BW-1:0];
        end else if (step && remain != '0) begin
            remain <= remain - 1'b1;
        end
    end

    assign last = (remain == CW'(1));

    // msb first mask, top tail bytes valid
    assign last_keep = (tail == '0) ? {`SM_KEEP_W{1'b1}}
                                    : ~({`SM_KEEP_W{1'b1}} >> tail);

endmodule

`default_nettype wire

// File: rtl/mux_fsm.sv
// packet state machine
`timescale 1ns/1ps
`default_nettype none

`include "stream_mux_macros.svh"

module mux_fsm
    import stream_mux_pkg::*;
#(
    parameter int START_STREAM_ID = 0
) (
    input  logic         user_clk,
    input  logic         user_rst_n,
    cache_rd_if.ctrl     rd,
    input  stream_mask_t grant,
    output logic         take,
    output logic         cnt_load,
    output logic         cnt_step,
    input  logic         cnt_last,
    input  keep_t        cnt_keep,
    output logic         m_axis_tvalid,
    output data_word_t   m_axis_tdata,
    output keep_t        m_axis_tkeep,
    output logic         m_axis_tlast,
    input  logic         m_axis_tready
);

    localparam int NS = `SM_NUM_STREAMS;
    localparam int IW = $clog2(NS);

    mux_state_e    state;
    logic [IW-1:0] sel;        // latched stream
    logic [IW-1:0] grant_idx;
    logic          out_free;   // output register may take a new beat
    logic          last_done;  // last beat leaves this edge
    logic          load_word;  // next payload word into output register
    data_word_t    hdr;

    always_comb begin
        grant_idx = '0;
        for (int i = 0; i < NS; i++) begin
            if (grant[i]) grant_idx = IW'(i);
        end
    end

    // ******************************
    // header word
    // ******************************
    always_comb begin
        hdr          = '0;
        hdr[125:120] = 6'(START_STREAM_ID) + 6'(sel);                  // ingress port
        hdr[107:96]  = 12'(rd.stat.len + pkt_len_t'(`SM_HDR_LEN_ADD)); // length
        hdr[87:80]   = 8'(`SM_DST_MODULE);                             // dst module
        hdr[71:64]   = rd.stat.pkt_id[7:0];                            // seq number
        hdr[31:0]    = rd.stat.timestamp[31:0];
    end

    assign out_free  = !m_axis_tvalid || m_axis_tready;
    assign last_done = m_axis_tvalid && m_axis_tready && m_axis_tlast;
    assign load_word = (state == PAYLOAD) && out_free && !last_done;

    assign take        = (state == IDLE) && (grant != '0);
    assign rd.sel      = sel;
    assign rd.pop_stat = (state == HEAD);
    assign rd.pop_data = load_word || (state == DISCARD);  // drop words unsent
    assign cnt_load    = (state == HEAD);                  // len from selected status
    assign cnt_step    = rd.pop_data;

    // ******************************
    // control
    // ******************************
    always_ff @(posedge user_clk or negedge user_rst_n) begin
        if (!user_rst_n) begin
            state         <= IDLE;
            sel           <= '0;
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        sel   <= grant_idx;
                        state <= HEAD;
                    end
                end
                HEAD: begin
                    if (rd.stat.valid) begin
                        m_axis_tvalid <= 1'b1;  // header goes out
                        m_axis_tlast  <= 1'b0;
                        state         <= PAYLOAD;
                    end else begin
                        state <= DISCARD;
                    end
                end
                PAYLOAD: begin
                    if (last_done) begin
                        m_axis_tvalid <= 1'b0;
                        m_axis_tlast  <= 1'b0;
                        state         <= IDLE;
                    end else if (load_word) begin
                        m_axis_tlast <= cnt_last;
                    end
                end
                DISCARD: begin
                    if (cnt_last) state <= IDLE;  // final word popped
                end
                default: state <= IDLE;
            endcase
        end
    end

    // beat contents
    always_ff @(posedge user_clk) begin
        if (state == HEAD) begin
            m_axis_tdata <= hdr;
            m_axis_tkeep <= '1;
        end else if (load_word) begin
            m_axis_tdata <= rd.data;
            m_axis_tkeep <= cnt_last ? cnt_keep : '1;
        end
    end

    a_stall_hold: assert property (@(posedge user_clk) disable iff (!user_rst_n)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
            && $stable(m_axis_tkeep) && $stable(m_axis_tlast));

endmodule

`default_nettype wire

// File: rtl/stream_mux.sv
// four stream packet mux
`timescale 1ns/1ps
`default_nettype none

`include "stream_mux_macros.svh"

module stream_mux
    import stream_mux_pkg::*;
#(
    parameter int START_STREAM_ID = 0
) (
    input  logic                              user_clk,
    input  logic                              user_rst_n,
    input  stream_mask_t                      s_data_wr,
    input  data_word_t   [`SM_NUM_STREAMS-1:0] s_data,
    input  stream_mask_t                      s_stat_wr,
    input  stream_stat_t [`SM_NUM_STREAMS-1:0] s_stat,
    output stream_mask_t                      s_rcv_ready,
    output logic                              m_axis_tvalid,
    output data_word_t                        m_axis_tdata,
    output keep_t                             m_axis_tkeep,
    output logic                              m_axis_tlast,
    input  logic                              m_axis_tready
);

    localparam int NS = `SM_NUM_STREAMS;

    data_word_t   data_in [NS];
    stream_stat_t stat_in [NS];
    stream_mask_t grant;
    logic         take;
    logic         cnt_load;
    logic         cnt_step;
    logic         cnt_last;
    keep_t        cnt_keep;

    cache_rd_if rd_bus ();

    always_comb begin
        for (int i = 0; i < NS; i++) begin
            data_in[i] = s_data[i];
            stat_in[i] = s_stat[i];
        end
    end

    // ******************************
    // blocks
    // ******************************
    stream_cache u_cache (
        .user_clk   (user_clk),
        .user_rst_n (user_rst_n),
        .data_wr    (s_data_wr),
        .data_in    (data_in),
        .stat_wr    (s_stat_wr),
        .stat_in    (stat_in),
        .rcv_ready  (s_rcv_ready),
        .rd         (rd_bus.cache)
    );

    rr_arbiter u_arb (
        .user_clk   (user_clk),
        .user_rst_n (user_rst_n),
        .req        (rd_bus.pending),  // streams with a status queued
        .take       (take),
        .grant      (grant)
    );

    word_counter u_cnt (
        .user_clk   (user_clk),
        .user_rst_n (user_rst_n),
        .load       (cnt_load),
        .len        (rd_bus.stat.len),
        .step       (cnt_step),
        .last       (cnt_last),
        .last_keep  (cnt_keep)
    );

    mux_fsm #(
        .START_STREAM_ID (START_STREAM_ID)
    ) u_fsm (
        .user_clk      (user_clk),
        .user_rst_n    (user_rst_n),
        .rd            (rd_bus.ctrl),
        .grant         (grant),
        .take          (take),
        .cnt_load      (cnt_load),
        .cnt_step      (cnt_step),
        .cnt_last      (cnt_last),
        .cnt_keep      (cnt_keep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready)
    );

endmodule

`default_nettype wire

// File: tests/stream_mux_tests.svh
// stream mux directed tests
`ifndef STREAM_MUX_TESTS_SVH
`define STREAM_MUX_TESTS_SVH

// ******************************
// expected values
// ******************************
function automatic data_word_t header_of(input int port, input stream_stat_t st);
    data_word_t h;
    h          = '0;
    h[125:120] = 6'(port);                                   // ingress port
    h[107:96]  = 12'(int'(st.len) + `SM_HDR_LEN_ADD);        // length + 32
    h[87:80]   = 8'(`SM_DST_MODULE);
    h[71:64]   = st.pkt_id[7:0];                             // low id byte
    h[31:0]    = st.timestamp[31:0];
    return h;
endfunction

// top len % 16 bytes valid, all of them on a full word
function automatic keep_t tail_keep(input int len);
    keep_t k;
    for (int b = 0; b < `SM_KEEP_W; b++) begin
        k[`SM_KEEP_W-1-b] = (len % 16 == 0) || (b < len % 16);
    end
    return k;
endfunction

task automatic expect_beat(input data_word_t d, input keep_t k, input logic l);
    exp_data.push_back(d);
    exp_keep.push_back(k);
    exp_last.push_back(l);
endtask

// ******************************
// tests
// ******************************
task automatic reset_state_test();
    start_test("reset_state");
    @(negedge user_clk);
    compare_bit("tvalid", 1'b0, m_axis_tvalid);
    compare_bit("tlast", 1'b0, m_axis_tlast);
    for (int i = 0; i < NS; i++) begin
        compare_bit($sformatf("rcv_ready[%0d]", i), 1'b1, s_rcv_ready[i]);
    end
    finish_test();
endtask

task automatic round_robin_test();
    start_test("round_robin");
    set_ready(1'b1);
    for (int s = 0; s < NS; s++) load_packet(s, 16 + 8 * s, 1'b1);  // 1 to 3 words
    post_status(4'b1111);                    // all queued before any grant
    check_beats();
    load_packet(1, 20, 1'b1);                // stream 1 wins over 3
    load_packet(3, 33, 1'b1);
    post_status(4'b1010);
    check_beats();
    load_packet(1, 16, 1'b1);                // pointer moves past stream 1
    post_status(4'b0010);
    check_beats();
    load_packet(2, 24, 1'b1);                // 2 before 0 only with rotation
    load_packet(0, 8, 1'b1);
    post_status(4'b0101);
    check_beats();
    finish_test();
endtask

task automatic single_packet_test();
    start_test("single_packet");
    load_packet(2, 40, 1'b1);                // 3 words, keep ff00 on the last
    post_status(4'b0100);
    check_beats();
    finish_test();
endtask

task automatic discard_test();
    start_test("discard");
    load_packet(1, 50, 1'b0);                // no beats expected
    post_status(4'b0010);
    load_packet(1, 24, 1'b1);
    post_status(4'b0010);
    check_beats();
    finish_test();
endtask

task automatic backpressure_random_test();
    int s;
    int len;
    start_test("backpressure_random");
    @(negedge user_clk);
    ready_rand = 1'b1;
    for (int p = 0; p < 3; p++) begin
        s   = $urandom_range(NS - 1, 0);
        len = $urandom_range(100, 1);
        load_packet(s, len, 1'b1);
        post_status(stream_mask_t'(1) << s);
        check_beats();
    end
    set_ready(1'b1);
    finish_test();
endtask

task automatic fill_ready_test();
    start_test("fill_ready");
    set_ready(1'b0);
    load_packet(0, 128 * 16, 1'b1);          // half the data fifo
    post_status(4'b0001);
    @(negedge user_clk);
    while (!m_axis_tvalid) @(negedge user_clk);  // header out, fsm now stalled
    repeat (4) @(negedge user_clk);
    compare_bit("rcv_ready[0] half full", 1'b0, s_rcv_ready[0]);
    set_ready(1'b1);
    check_beats();
    compare_bit("rcv_ready[0] drained", 1'b1, s_rcv_ready[0]);
    finish_test();
endtask

`endif

// File: tests/stream_mux_tb.sv
// stream mux testbench
`timescale 1ns/1ps
`default_nettype none

`include "stream_mux_macros.svh"

module stream_mux_tb
    import stream_mux_pkg::*;
();

    localparam int NS         = `SM_NUM_STREAMS;
    localparam int MAX_CYCLES = 20000;  // a few thousand used by all tests

    logic                  user_clk;
    logic                  user_rst_n;
    stream_mask_t          s_data_wr;
    data_word_t   [NS-1:0] s_data;
    stream_mask_t          s_stat_wr;
    stream_stat_t [NS-1:0] s_stat;
    stream_mask_t          s_rcv_ready;
    logic                  m_axis_tvalid;
    data_word_t            m_axis_tdata;
    keep_t                 m_axis_tkeep;
    logic                  m_axis_tlast;
    logic                  m_axis_tready;
    logic                  ready_rand;      // tready from $urandom

    data_word_t            exp_data [$];    // beats still due
    keep_t                 exp_keep [$];
    logic                  exp_last [$];
    data_word_t            got_data [$];    // beats seen on the output
    keep_t                 got_keep [$];
    logic                  got_last [$];
    stream_stat_t [NS-1:0] staged;          // status waiting per stream
    string                 test_name;
    int                    errors       = 0;
    int                    errors_mark  = 0;
    int                    tests_run    = 0;
    int                    tests_failed = 0;
    int                    cycles       = 0;

    stream_mux #(
        .START_STREAM_ID (0)
    ) UUT (
        .user_clk      (user_clk),
        .user_rst_n    (user_rst_n),
        .s_data_wr     (s_data_wr),
        .s_data        (s_data),
        .s_stat_wr     (s_stat_wr),
        .s_stat        (s_stat),
        .s_rcv_ready   (s_rcv_ready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready)
    );

    initial begin
        user_clk = 1'b0;
        forever #2 user_clk = ~user_clk;  // 4 ns period
    end

    // ******************************
    // timeout and back-pressure
    // ******************************
    always @(posedge user_clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("Something failed");
            $finish;
        end
    end

    initial begin : ready_driver
        forever begin
            @(posedge user_clk);
            if (ready_rand) m_axis_tready <= 1'($urandom);  // coin flip per cycle
        end
    end

    // beat moves on the edge after this negedge
    task automatic collect_beats();
        forever begin
            @(negedge user_clk);
            if (m_axis_tvalid && m_axis_tready) begin
                got_data.push_back(m_axis_tdata);
                got_keep.push_back(m_axis_tkeep);
                got_last.push_back(m_axis_tlast);
            end
        end
    endtask

    initial collect_beats();

    // ******************************
    // compare tasks
    // ******************************
    task automatic compare_word(input string what, input data_word_t exp,
                                input data_word_t act);
        if (exp !== act) begin
            errors++;
            $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_keep(input string what, input keep_t exp, input keep_t act);
        if (exp !== act) begin
            errors++;
            $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("Error %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        errors_mark = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != errors_mark) tests_failed++;
        $display("test %-20s %s", test_name, (errors == errors_mark) ? "pass" : "FAIL");
    endtask

    // ******************************
    // stream driver
    // ******************************
    task automatic load_packet(input int s, input int len, input logic valid);
        int         n;
        data_word_t w;
        n                   = (len + 15) / 16;          // words in the packet
        staged[s].valid     = valid;
        staged[s].len       = pkt_len_t'(len);
        staged[s].pkt_id    = 16'($urandom);
        staged[s].timestamp = {$urandom, $urandom};
        if (valid) expect_beat(header_of(s, staged[s]), '1, 1'b0);
        for (int k = 0; k < n; k++) begin
            w = {$urandom, $urandom, $urandom, $urandom};
            @(negedge user_clk);
            while (!s_rcv_ready[s]) @(negedge user_clk);  // writer holds off
            @(posedge user_clk);
            s_data_wr <= stream_mask_t'(1) << s;
            s_data[s] <= w;
            @(posedge user_clk);
            s_data_wr <= '0;                               // one word per pulse
            if (valid) expect_beat(w, (k == n - 1) ? tail_keep(len) : '1, k == n - 1);
        end
    endtask

    task automatic post_status(input stream_mask_t m);
        @(posedge user_clk);
        s_stat_wr <= m;       // all masked streams in one cycle
        s_stat    <= staged;
        @(posedge user_clk);
        s_stat_wr <= '0;
    endtask

    // waits for every due beat, then compares in order
    task automatic check_beats();
        int b;
        b = 0;
        while (got_data.size() < exp_data.size()) @(negedge user_clk);
        repeat (4) @(negedge user_clk);                    // room for stray beats
        if (got_data.size() != exp_data.size()) begin
            errors++;
            $display("%s: %0d beats came out where %0d were due", test_name,
                     got_data.size(), exp_data.size());
        end
        while (exp_data.size() > 0 && got_data.size() > 0) begin
            compare_word($sformatf("beat %0d tdata", b), exp_data.pop_front(),
                         got_data.pop_front());
            compare_keep($sformatf("beat %0d tkeep", b), exp_keep.pop_front(),
                         got_keep.pop_front());
            compare_bit($sformatf("beat %0d tlast", b), exp_last.pop_front(),
                        got_last.pop_front());
            b++;
        end
        exp_data.delete();
        exp_keep.delete();
        exp_last.delete();
        got_data.delete();
        got_keep.delete();
        got_last.delete();
    endtask

    task automatic set_ready(input logic v);
        @(negedge user_clk);
        ready_rand = 1'b0;
        @(posedge user_clk);
        m_axis_tready <= v;
    endtask

    `include "stream_mux_tests.svh"

    initial begin : main
        void'($urandom(32'h4a9a_ab46));
        user_rst_n    = 1'b0;
        s_data_wr     = '0;
        s_data        = '0;
        s_stat_wr     = '0;
        s_stat        = '0;
        staged        = '0;
        m_axis_tready = 1'b0;
        ready_rand    = 1'b0;
        repeat (8) @(posedge user_clk);
        user_rst_n <= 1'b1;
        reset_state_test();
        round_robin_test();      // runs while the pointer still favours stream 0
        single_packet_test();
        discard_test();
        backpressure_random_test();
        fill_ready_test();
        $display("tests %0d, failing %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: stream_mux.f
+incdir+rtl
+incdir+tests
rtl/stream_mux_pkg.sv
rtl/cache_rd_if.sv
rtl/stream_cache.sv
rtl/rr_arbiter.sv
rtl/word_counter.sv
rtl/mux_fsm.sv
rtl/stream_mux.sv
tests/stream_mux_tb.sv

// File: Makefile
# Verilator build and run for stream_mux

SIM  = obj_dir/Vstream_mux_tb
SRCS = $(shell grep -v '^+' stream_mux.f) $(wildcard rtl/*.svh tests/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): stream_mux.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module stream_mux_tb -f stream_mux.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Something failed" sim.log; then exit 1; fi
	@grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
